/* filelist.f */
hw/wb_com_pkg.sv
hw/com_req_if.sv
hw/wb_com_fifo.sv
hw/wb_com_master.sv
hw/wb_com_slave.sv
hw/wb_com_top.sv
bench/tb_clock.sv
bench/wb_com_asserts.sv
bench/wb_com_tb.sv

/* Makefile */
# Verilator build and run of the commutator testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module wb_com_tb -Mdir obj_dir

# the log decides the result, not the simulator exit code
run: compile
	./obj_dir/Vwb_com_tb +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "Testbench failed" $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/wb_com_tb.sv */
// top-level commutator testbench that runs a random pipelined master against two slave models
`timescale 1ns/1ps
`default_nettype none

// --------------------
// wishbone slave model
// --------------------
module slave_model #(
  parameter logic [31:0] fill_key = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        heavy_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        stall_o
);

  logic [31:0] mem [logic [31:0]];
  logic [31:0] word;
  logic [31:0] dat_q   = '0;
  logic        ack_q   = 1'b0;
  logic        stall_q = 1'b0;
  logic        busy    = 1'b0;
  int          delay   = 0;

  assign dat_o   = dat_q;
  assign ack_o   = ack_q;
  assign stall_o = stall_q;

  always @(posedge clk_i) begin
    ack_q   <= 1'b0;
    // heavy mode stalls three cycles in four
    stall_q <= heavy_i ? ($urandom % 4 != 0) : ($urandom % 4 == 0);
    if (rst_i) begin
      busy = 1'b0;
    end else if (busy) begin
      if (delay == 0) begin
        ack_q <= 1'b1;
        busy = 1'b0;
      end else begin
        delay = delay - 1;
      end
    end else if (cyc_i && stb_i && !stall_q) begin
      busy  = 1'b1;
      delay = heavy_i ? int'($urandom % 8) : int'($urandom % 2);
      if (we_i) begin
        // only the selected bytes are written
        word = mem.exists(adr_i) ? mem[adr_i] : adr_i ^ fill_key;
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) word[b*8 +: 8] = dat_i[b*8 +: 8];
        end
        mem[adr_i] = word;
        dat_q <= '0;
      end else begin
        dat_q <= mem.exists(adr_i) ? mem[adr_i] : adr_i ^ fill_key;
      end
    end
  end

endmodule

module wb_com_tb;

  localparam int          n_directed = 6;
  localparam int          n_light    = 60;
  localparam int          n_heavy    = 40;
  localparam int          n_req      = n_directed + 2 * n_light + n_heavy;
  localparam logic [31:0] fill_key   = 32'h5ac3_1e0f;

  logic        clk;
  logic        rst;
  logic        heavy;
  logic [31:0] m_adr;
  logic [31:0] m_dat;
  logic [3:0]  m_sel;
  logic        m_cyc;
  logic        m_stb;
  logic        m_we;
  logic [31:0] m_rdat;
  logic        m_ack;
  logic        m_stall;
  logic        m_err;
  logic [31:0] s0_adr;
  logic [31:0] s0_wdat;
  logic [31:0] s0_rdat;
  logic [3:0]  s0_sel;
  logic        s0_cyc;
  logic        s0_stb;
  logic        s0_we;
  logic        s0_ack;
  logic        s0_stall;
  logic [31:0] s1_adr;
  logic [31:0] s1_wdat;
  logic [31:0] s1_rdat;
  logic [3:0]  s1_sel;
  logic        s1_cyc;
  logic        s1_stb;
  logic        s1_we;
  logic        s1_ack;
  logic        s1_stall;

  // reference state and scoreboard
  logic [31:0] ref_mem [logic [31:0]];
  logic [32:0] exp_q [$];
  logic        taken      = 1'b0;
  logic        saw_stall  = 1'b0;
  int          val_errs   = 0;
  int          other_errs = 0;
  int          n_acc      = 0;
  int          n_rsp      = 0;

  tb_clock clock_i (.clk_o(clk));

  wb_com_top wb_com_top_i (
    .clk_i(clk), .rst_i(rst),
    .m_adr_i(m_adr), .m_dat_i(m_dat), .m_sel_i(m_sel), .m_cyc_i(m_cyc),
    .m_stb_i(m_stb), .m_we_i(m_we), .m_dat_o(m_rdat), .m_ack_o(m_ack),
    .m_stall_o(m_stall), .m_err_o(m_err),
    .s0_adr_o(s0_adr), .s0_dat_o(s0_wdat), .s0_sel_o(s0_sel), .s0_cyc_o(s0_cyc),
    .s0_stb_o(s0_stb), .s0_we_o(s0_we), .s0_dat_i(s0_rdat), .s0_ack_i(s0_ack),
    .s0_stall_i(s0_stall),
    .s1_adr_o(s1_adr), .s1_dat_o(s1_wdat), .s1_sel_o(s1_sel), .s1_cyc_o(s1_cyc),
    .s1_stb_o(s1_stb), .s1_we_o(s1_we), .s1_dat_i(s1_rdat), .s1_ack_i(s1_ack),
    .s1_stall_i(s1_stall)
  );

  slave_model #(.fill_key(fill_key)) slave0_model_i (
    .clk_i(clk), .rst_i(rst), .heavy_i(heavy), .cyc_i(s0_cyc), .stb_i(s0_stb),
    .we_i(s0_we), .adr_i(s0_adr), .sel_i(s0_sel), .dat_i(s0_wdat), .dat_o(s0_rdat),
    .ack_o(s0_ack), .stall_o(s0_stall)
  );

  slave_model #(.fill_key(fill_key)) slave1_model_i (
    .clk_i(clk), .rst_i(rst), .heavy_i(heavy), .cyc_i(s1_cyc), .stb_i(s1_stb),
    .we_i(s1_we), .adr_i(s1_adr), .sel_i(s1_sel), .dat_i(s1_wdat), .dat_o(s1_rdat),
    .ack_o(s1_ack), .stall_o(s1_stall)
  );

  bind wb_com_top wb_com_asserts asserts_i (
    .clk_i(clk_i), .rst_i(rst_i), .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i),
    .m_ack_i(m_ack_o), .m_err_i(m_err_o), .m_stall_i(m_stall_o),
    .s0_cyc_i(s0_cyc_o), .s0_stb_i(s0_stb_o), .s0_ack_i(s0_ack_i),
    .s1_cyc_i(s1_cyc_o), .s1_stb_i(s1_stb_o), .s1_ack_i(s1_ack_i)
  );

  // --------------------
  // reference model
  // --------------------
  // unwritten words read back the fill pattern
  function automatic logic [31:0] ref_word(input logic [31:0] adr);
    return ref_mem.exists(adr) ? ref_mem[adr] : adr ^ fill_key;
  endfunction

  // bytes enabled by sel take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] dat,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[b*8 +: 8] = dat[b*8 +: 8];
    end
    return res;
  endfunction

  // expected {err, read data} for one request
  // writes answer with zero data
  function automatic logic [32:0] expected_rsp(input logic [31:0] adr, input logic we);
    logic hit0;
    logic hit1;
    hit0 = (adr & ~wb_com_pkg::s0_mask) == wb_com_pkg::s0_base;
    hit1 = (adr & ~wb_com_pkg::s1_mask) == wb_com_pkg::s1_base;
    if (!hit0 && !hit1) return {1'b1, 32'h0};
    if (we) return {1'b0, 32'h0};
    return {1'b0, ref_word(adr)};
  endfunction

  function automatic logic [31:0] random_addr();
    logic [31:0] off;
    off = ($urandom % 16) * 4;
    case ($urandom % 5)
      0, 1:    return wb_com_pkg::s0_base | off;
      2, 3:    return wb_com_pkg::s1_base | off;
      default: return (($urandom % 2) != 0 ? 32'h0000_0800 : 32'h8000_1000) | off;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      val_errs = val_errs + 1;
      $display("** Error: %s is %h, expected %h at %0t", name, got, want, $time);
    end
  endtask

  // present one request and hold it until taken
  task automatic issue(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                       input logic [31:0] dat);
    m_cyc <= 1'b1;
    m_stb <= 1'b1;
    m_adr <= adr;
    m_we  <= we;
    m_sel <= sel;
    m_dat <= we ? dat : 32'h0;
    @(posedge clk);
    while (!taken) @(posedge clk);
  endtask

  task automatic pause(input int n);
    m_stb <= 1'b0;
    m_cyc <= 1'($urandom % 2);
    repeat (n) @(posedge clk);
  endtask

  // --------------------
  // monitor and compare at mid-cycle
  // --------------------
  always @(negedge clk) begin : compare
    logic [32:0] want;
    taken = 1'b0;
    if (!rst) begin
      if (m_cyc && m_stb && m_stall) saw_stall = 1'b1;
      if (m_ack || m_err) begin
        n_rsp = n_rsp + 1;
        if (exp_q.size() == 0) begin
          other_errs = other_errs + 1;
          $display("response at %0t with no request outstanding", $time);
        end else begin
          want = exp_q.pop_front();
          check_value("m_ack_o", 32'(m_ack), 32'(!want[32]));
          check_value("m_err_o", 32'(m_err), 32'(want[32]));
          if (m_ack && !want[32]) check_value("m_dat_o", m_rdat, want[31:0]);
        end
      end
      if (m_cyc && m_stb && !m_stall) begin
        taken = 1'b1;
        n_acc = n_acc + 1;
        want  = expected_rsp(m_adr, m_we);
        exp_q.push_back(want);
        if (m_we && !want[32]) ref_mem[m_adr] = merge_bytes(ref_word(m_adr), m_dat, m_sel);
      end
    end
  end

  initial begin : watchdog
    repeat (n_req * 40) @(posedge clk);
    $display("timeout, %0d of %0d accepted requests answered", n_rsp, n_acc);
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    int i;
    int asrt_errs;
    void'($urandom(32'h312e));
    rst   = 1'b1;
    heavy = 1'b0;
    m_adr = '0;
    m_dat = '0;
    m_sel = 4'hf;
    m_cyc = 1'b0;
    m_stb = 1'b0;
    m_we  = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // write then read back per window with a miss in between
    issue(wb_com_pkg::s0_base + 32'h10, 1'b1, 4'hf, 32'h1357_9bdf);
    issue(wb_com_pkg::s0_base + 32'h10, 1'b0, 4'hf, 32'h0);
    issue(wb_com_pkg::s1_base + 32'h20, 1'b1, 4'hf, 32'h2468_ace0);
    issue(32'h0000_2000, 1'b0, 4'hf, 32'h0);
    issue(wb_com_pkg::s1_base + 32'h20, 1'b0, 4'hf, 32'h0);
    issue(wb_com_pkg::s0_base + 32'h10, 1'b0, 4'hf, 32'h0);
    for (i = 0; i < n_light; i++) begin
      issue(random_addr(), 1'($urandom % 2), 4'($urandom), $urandom);
      if ($urandom % 3 == 0) pause(int'($urandom % 4) + 1);
    end
    // back-to-back burst against slow slaves
    heavy <= 1'b1;
    for (i = 0; i < n_heavy; i++) begin
      issue(random_addr(), 1'($urandom % 2), 4'($urandom), $urandom);
    end
    heavy <= 1'b0;
    for (i = 0; i < n_light; i++) begin
      issue(random_addr(), 1'($urandom % 2), 4'($urandom), $urandom);
      if ($urandom % 3 == 0) pause(int'($urandom % 4) + 1);
    end
    m_cyc <= 1'b0;
    m_stb <= 1'b0;
    while (n_rsp != n_acc) @(posedge clk);
    repeat (20) @(posedge clk);
    if (n_acc != n_req || n_rsp != n_acc) begin
      other_errs = other_errs + 1;
      $display("%0d requests issued, %0d accepted, %0d answered", n_req, n_acc, n_rsp);
    end
    if (!saw_stall) begin
      other_errs = other_errs + 1;
      $display("m_stall_o never rose while a request was offered");
    end
    asrt_errs = wb_com_top_i.asserts_i.fail_count;
    $display("errors: %0d value, %0d other, %0d assertion", val_errs, other_errs, asrt_errs);
    if (val_errs == 0 && other_errs == 0 && asrt_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/wb_com_asserts.sv */
// protocol assertions that the testbench binds into the commutator top level
`timescale 1ns/1ps
`default_nettype none

module wb_com_asserts (
  input logic clk_i,
  input logic rst_i,
  input logic m_cyc_i,
  input logic m_stb_i,
  input logic m_ack_i,
  input logic m_err_i,
  input logic m_stall_i,
  input logic s0_cyc_i,
  input logic s0_stb_i,
  input logic s0_ack_i,
  input logic s1_cyc_i,
  input logic s1_stb_i,
  input logic s1_ack_i
);

  int fail_count = 0;
  int pending;

  // requests taken by the master handshake and not yet answered
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(m_cyc_i && m_stb_i && !m_stall_i)
                         - int'(m_ack_i || m_err_i);
    end
  end

  // never both kinds of answer in one cycle
  rsp_excl: assert property (@(posedge clk_i) !(m_ack_i && m_err_i))
    else begin
      fail_count = fail_count + 1;
      $error("m_ack_o and m_err_o high in the same cycle");
    end

  rsp_tracked: assert property (@(posedge clk_i) disable iff (rst_i)
                                (m_ack_i || m_err_i) |-> pending > 0)
    else begin
      fail_count = fail_count + 1;
      $error("response while no request is outstanding");
    end

  // --------------------
  // slave cycles
  // --------------------
  cyc0_held: assert property (@(posedge clk_i) disable iff (rst_i)
                              s0_cyc_i && !s0_ack_i |=> s0_cyc_i)
    else begin
      fail_count = fail_count + 1;
      $error("s0_cyc_o dropped before ack");
    end

  cyc1_held: assert property (@(posedge clk_i) disable iff (rst_i)
                              s1_cyc_i && !s1_ack_i |=> s1_cyc_i)
    else begin
      fail_count = fail_count + 1;
      $error("s1_cyc_o dropped before ack");
    end

  // flags quiet once reset has been seen for a full cycle
  rst_quiet: assert property (@(posedge clk_i) rst_i && $past(rst_i) |->
                              !(m_ack_i || m_err_i || m_stall_i || s0_cyc_i || s0_stb_i
                                || s1_cyc_i || s1_stb_i))
    else begin
      fail_count = fail_count + 1;
      $error("flag output high during reset");
    end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// free-running testbench clock, instantiated once by the commutator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  // 100 ns period
  localparam int half_ns = 50;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(half_ns) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* hw/wb_com_top.sv */
// commutator top level, connects one pipelined wishbone master to two wishbone slaves by address
`timescale 1ns/1ps
`default_nettype none

module wb_com_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // --------------------
  // master port
  // --------------------
  input  logic [wb_com_pkg::addr_w-1:0] m_adr_i,
  input  logic [wb_com_pkg::data_w-1:0] m_dat_i,
  input  logic [wb_com_pkg::sel_w-1:0]  m_sel_i,
  input  logic                          m_cyc_i,
  input  logic                          m_stb_i,
  input  logic                          m_we_i,
  output logic [wb_com_pkg::data_w-1:0] m_dat_o,
  output logic                          m_ack_o,
  output logic                          m_stall_o,
  output logic                          m_err_o,
  // --------------------
  // slave 0 port
  // --------------------
  output logic [wb_com_pkg::addr_w-1:0] s0_adr_o,
  output logic [wb_com_pkg::data_w-1:0] s0_dat_o,
  output logic [wb_com_pkg::sel_w-1:0]  s0_sel_o,
  output logic                          s0_cyc_o,
  output logic                          s0_stb_o,
  output logic                          s0_we_o,
  input  logic [wb_com_pkg::data_w-1:0] s0_dat_i,
  input  logic                          s0_ack_i,
  input  logic                          s0_stall_i,
  // --------------------
  // slave 1 port
  // --------------------
  output logic [wb_com_pkg::addr_w-1:0] s1_adr_o,
  output logic [wb_com_pkg::data_w-1:0] s1_dat_o,
  output logic [wb_com_pkg::sel_w-1:0]  s1_sel_o,
  output logic                          s1_cyc_o,
  output logic                          s1_stb_o,
  output logic                          s1_we_o,
  input  logic [wb_com_pkg::data_w-1:0] s1_dat_i,
  input  logic                          s1_ack_i,
  input  logic                          s1_stall_i
);

  logic [wb_com_pkg::data_w-1:0] rsp0_data;
  logic                          rsp0_empty;
  logic                          rsp0_rden;
  logic [wb_com_pkg::data_w-1:0] rsp1_data;
  logic                          rsp1_empty;
  logic                          rsp1_rden;

  com_req_if req0_if ();
  com_req_if req1_if ();

  wb_com_master master_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .m_adr_i      (m_adr_i),
    .m_dat_i      (m_dat_i),
    .m_sel_i      (m_sel_i),
    .m_cyc_i      (m_cyc_i),
    .m_stb_i      (m_stb_i),
    .m_we_i       (m_we_i),
    .m_dat_o      (m_dat_o),
    .m_ack_o      (m_ack_o),
    .m_stall_o    (m_stall_o),
    .m_err_o      (m_err_o),
    .req0         (req0_if.master_mp),
    .req1         (req1_if.master_mp),
    .rsp0_data_i  (rsp0_data),
    .rsp0_empty_i (rsp0_empty),
    .rsp0_rden_o  (rsp0_rden),
    .rsp1_data_i  (rsp1_data),
    .rsp1_empty_i (rsp1_empty),
    .rsp1_rden_o  (rsp1_rden)
  );

  wb_com_slave slave0_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req         (req0_if.slave_mp),
    .adr_o       (s0_adr_o),
    .dat_o       (s0_dat_o),
    .sel_o       (s0_sel_o),
    .cyc_o       (s0_cyc_o),
    .stb_o       (s0_stb_o),
    .we_o        (s0_we_o),
    .dat_i       (s0_dat_i),
    .ack_i       (s0_ack_i),
    .stall_i     (s0_stall_i),
    .rsp_data_o  (rsp0_data),
    .rsp_empty_o (rsp0_empty),
    .rsp_rden_i  (rsp0_rden)
  );

  wb_com_slave slave1_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req         (req1_if.slave_mp),
    .adr_o       (s1_adr_o),
    .dat_o       (s1_dat_o),
    .sel_o       (s1_sel_o),
    .cyc_o       (s1_cyc_o),
    .stb_o       (s1_stb_o),
    .we_o        (s1_we_o),
    .dat_i       (s1_dat_i),
    .ack_i       (s1_ack_i),
    .stall_i     (s1_stall_i),
    .rsp_data_o  (rsp1_data),
    .rsp_empty_o (rsp1_empty),
    .rsp_rden_i  (rsp1_rden)
  );

endmodule

`default_nettype wire

/* hw/wb_com_slave.sv */
// slave side of the commutator, replays queued requests on one wishbone slave and buffers replies
`timescale 1ns/1ps
`default_nettype none

module wb_com_slave (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // queued requests from the master side
  com_req_if.slave_mp                   req,
  // wishbone slave port
  output logic [wb_com_pkg::addr_w-1:0] adr_o,
  output logic [wb_com_pkg::data_w-1:0] dat_o,
  output logic [wb_com_pkg::sel_w-1:0]  sel_o,
  output logic                          cyc_o,
  output logic                          stb_o,
  output logic                          we_o,
  input  logic [wb_com_pkg::data_w-1:0] dat_i,
  input  logic                          ack_i,
  input  logic                          stall_i,
  // return path to the master side
  output logic [wb_com_pkg::data_w-1:0] rsp_data_o,
  output logic                          rsp_empty_o,
  input  logic                          rsp_rden_i
);

  logic [1:0]                    state;
  logic                          start;
  logic                          ack_ok;
  logic                          rsp_full;
  logic [wb_com_pkg::data_w-1:0] rsp_word;

  // only start when the reply has somewhere to go
  assign start     = (state == wb_com_pkg::st_idle) & ~req.hempty & ~rsp_full;
  assign req.hrden = start;
  assign req.drden = start & req.header[0];

  // ack counts once the strobe has been taken
  assign ack_ok = ack_i & (((state == wb_com_pkg::st_strobe) & ~stall_i)
                         | (state == wb_com_pkg::st_wait));

  // --------------------
  // request payload
  // --------------------
  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_o <= req.header[wb_com_pkg::hdr_w-1 -: wb_com_pkg::addr_w];
      sel_o <= req.header[wb_com_pkg::sel_w:1];
      we_o  <= req.header[0];
      dat_o <= req.header[0] ? req.data : '0;
    end
  end

  // --------------------
  // cycle sequencer
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= wb_com_pkg::st_idle;
      cyc_o <= 1'b0;
      stb_o <= 1'b0;
    end else begin
      case (state)
        wb_com_pkg::st_idle: begin
          if (start) begin
            cyc_o <= 1'b1;
            stb_o <= 1'b1;
            state <= wb_com_pkg::st_strobe;
          end
        end
        wb_com_pkg::st_strobe: begin
          if (!stall_i) begin
            stb_o <= 1'b0;
            if (ack_i) begin
              cyc_o <= 1'b0;
              state <= wb_com_pkg::st_idle;
            end else begin
              state <= wb_com_pkg::st_wait;
            end
          end
        end
        wb_com_pkg::st_wait: begin
          if (ack_i) begin
            cyc_o <= 1'b0;
            state <= wb_com_pkg::st_idle;
          end
        end
        default: begin
          cyc_o <= 1'b0;
          stb_o <= 1'b0;
          state <= wb_com_pkg::st_idle;
        end
      endcase
    end
  end

  // writes return zero
  assign rsp_word = we_o ? '0 : dat_i;

  wb_com_fifo #(.width(wb_com_pkg::data_w)) rsp_fifo_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (ack_ok),
    .wr_data_i (rsp_word),
    .rd_en_i   (rsp_rden_i),
    .rd_data_o (rsp_data_o),
    .full_o    (rsp_full),
    .empty_o   (rsp_empty_o)
  );

endmodule

`default_nettype wire

/* hw/wb_com_master.sv */
// master side of the commutator, decodes requests into slave FIFOs and returns responses in order
`timescale 1ns/1ps
`default_nettype none

module wb_com_master (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // wishbone master port
  input  logic [wb_com_pkg::addr_w-1:0] m_adr_i,
  input  logic [wb_com_pkg::data_w-1:0] m_dat_i,
  input  logic [wb_com_pkg::sel_w-1:0]  m_sel_i,
  input  logic                          m_cyc_i,
  input  logic                          m_stb_i,
  input  logic                          m_we_i,
  output logic [wb_com_pkg::data_w-1:0] m_dat_o,
  output logic                          m_ack_o,
  output logic                          m_stall_o,
  output logic                          m_err_o,
  // request paths to both slave sides
  com_req_if.master_mp                  req0,
  com_req_if.master_mp                  req1,
  // return paths
  input  logic [wb_com_pkg::data_w-1:0] rsp0_data_i,
  input  logic                          rsp0_empty_i,
  output logic                          rsp0_rden_o,
  input  logic [wb_com_pkg::data_w-1:0] rsp1_data_i,
  input  logic                          rsp1_empty_i,
  output logic                          rsp1_rden_o
);

  logic                               s0_hit;
  logic                               s1_hit;
  logic                               accept;
  logic                               rsp_done;
  logic                               sel1;
  logic [wb_com_pkg::hdr_w-1:0]       header;
  logic                               s0_hfull;
  logic                               s0_dfull;
  logic                               s1_hfull;
  logic                               s1_dfull;
  // tracker, newest entry at bit 0
  logic [wb_com_pkg::track_depth-1:0] trk_s1;
  logic [wb_com_pkg::track_depth-1:0] trk_miss;
  logic [wb_com_pkg::track_depth-1:0] trk_head;

  // --------------------
  // address decode
  // --------------------
  assign s0_hit = (m_adr_i & ~wb_com_pkg::s0_mask) == wb_com_pkg::s0_base;
  assign s1_hit = (m_adr_i & ~wb_com_pkg::s1_mask) == wb_com_pkg::s1_base;

  // stall on a full target FIFO or a full tracker
  assign m_stall_o = (s0_hit & (s0_hfull | s0_dfull))
                   | (s1_hit & (s1_hfull | s1_dfull))
                   | trk_head[wb_com_pkg::track_depth-1];

  assign accept = m_cyc_i & m_stb_i & ~m_stall_o;
  assign header = {m_adr_i, m_sel_i, m_we_i};

  // --------------------
  // in-order tracking
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      trk_s1   <= '0;
      trk_miss <= '0;
    end else if (accept) begin
      trk_s1   <= {trk_s1[wb_com_pkg::track_depth-2:0], s1_hit};
      trk_miss <= {trk_miss[wb_com_pkg::track_depth-2:0], ~s0_hit & ~s1_hit};
    end
  end

  // head marks the oldest entry; it stays put when an accept and a response coincide
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      trk_head <= '0;
    end else if (rsp_done && !accept) begin
      trk_head <= {1'b0, trk_head[wb_com_pkg::track_depth-1:1]};
    end else if (accept && !rsp_done) begin
      trk_head <= {trk_head[wb_com_pkg::track_depth-2:0], ~|trk_head};
    end
  end

  assign sel1    = |(trk_head & trk_s1);
  assign m_err_o = |(trk_head & trk_miss);
  assign m_ack_o = (|trk_head) & ~m_err_o & (sel1 ? ~rsp1_empty_i : ~rsp0_empty_i);
  assign m_dat_o = sel1 ? rsp1_data_i : rsp0_data_i;

  assign rsp_done    = m_ack_o | m_err_o;
  assign rsp0_rden_o = m_ack_o & ~sel1;
  assign rsp1_rden_o = m_ack_o & sel1;

  // --------------------
  // request FIFOs
  // --------------------
  wb_com_fifo #(.width(wb_com_pkg::hdr_w)) s0_hdr_fifo_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (accept & s0_hit),
    .wr_data_i (header),
    .rd_en_i   (req0.hrden),
    .rd_data_o (req0.header),
    .full_o    (s0_hfull),
    .empty_o   (req0.hempty)
  );

  // write data only, reads carry no payload
  wb_com_fifo #(.width(wb_com_pkg::data_w)) s0_dat_fifo_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (accept & s0_hit & m_we_i),
    .wr_data_i (m_dat_i),
    .rd_en_i   (req0.drden),
    .rd_data_o (req0.data),
    .full_o    (s0_dfull),
    .empty_o   ()
  );

  wb_com_fifo #(.width(wb_com_pkg::hdr_w)) s1_hdr_fifo_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (accept & s1_hit),
    .wr_data_i (header),
    .rd_en_i   (req1.hrden),
    .rd_data_o (req1.header),
    .full_o    (s1_hfull),
    .empty_o   (req1.hempty)
  );

  wb_com_fifo #(.width(wb_com_pkg::data_w)) s1_dat_fifo_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (accept & s1_hit & m_we_i),
    .wr_data_i (m_dat_i),
    .rd_en_i   (req1.drden),
    .rd_data_o (req1.data),
    .full_o    (s1_dfull),
    .empty_o   ()
  );

endmodule

`default_nettype wire

/* hw/wb_com_fifo.sv */
// synchronous show-ahead FIFO with full and empty flags, holds headers, write data and responses
`timescale 1ns/1ps
`default_nettype none

module wb_com_fifo #(
  parameter int width = 32
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             wr_en_i,
  input  logic [width-1:0] wr_data_i,
  input  logic             rd_en_i,
  output logic [width-1:0] rd_data_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [width-1:0]                 mem [wb_com_pkg::fifo_depth];
  logic [wb_com_pkg::fifo_asize-1:0] wr_ptr;
  logic [wb_com_pkg::fifo_asize-1:0] rd_ptr;
  logic [wb_com_pkg::fifo_asize:0]   count;
  logic                             wr_ok;
  logic                             rd_ok;

  // writes into a full FIFO and pops of an empty one are ignored
  assign wr_ok = wr_en_i & ~full_o;
  assign rd_ok = rd_en_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // --------------------
  // pointers and fill level
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // show-ahead, head entry is always on the output
  assign rd_data_o = mem[rd_ptr];

  // depth is a power of two, so the top count bit means full
  assign full_o  = count[wb_com_pkg::fifo_asize];
  assign empty_o = (count == '0);

endmodule

`default_nettype wire

/* hw/com_req_if.sv */
// request path of one slave, carries the show-ahead header and data FIFO outputs and pops
`timescale 1ns/1ps
`default_nettype none

interface com_req_if;

  // head entries of the header and data FIFOs
  logic [wb_com_pkg::hdr_w-1:0]  header;
  logic [wb_com_pkg::data_w-1:0] data;
  logic                          hempty;

  // pops from the slave side
  logic                          hrden;
  logic                          drden;

  modport master_mp (
    output header, data, hempty,
    input  hrden, drden
  );

  modport slave_mp (
    input  header, data, hempty,
    output hrden, drden
  );

endinterface

`default_nettype wire

/* hw/wb_com_pkg.sv */
// shared widths, FIFO and tracker sizes, address windows and sequencer states of the commutator
`default_nettype none

package wb_com_pkg;

  // --------------------
  // wishbone bus widths
  // --------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int sel_w  = data_w / 8;

  // header word is {address, select, write enable}
  localparam int hdr_w = addr_w + sel_w + 1;

  // --------------------
  // buffering
  // --------------------
  localparam int fifo_asize = 2;
  localparam int fifo_depth = 1 << fifo_asize;

  // outstanding requests held by the master side
  localparam int track_depth = 8;

  // --------------------
  // address windows
  // --------------------
  localparam logic [addr_w-1:0] s0_base = 32'h0000_0000;
  localparam logic [addr_w-1:0] s0_mask = 32'h0000_03ff;
  localparam logic [addr_w-1:0] s1_base = 32'h0000_1000;
  localparam logic [addr_w-1:0] s1_mask = 32'h0000_03ff;

  // slave side sequencer states
  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_strobe = 2'd1;
  localparam logic [1:0] st_wait   = 2'd2;

endpackage

`default_nettype wire
